/* verilog/mrpw_pkg.sv */
package mrpw_pkg;

  // ##################################################################
  // sizes
  // ##################################################################

  localparam int WIDTH   = 16;
  localparam int NUMADDR = 64;
  localparam int BITADDR = 6;
  localparam int NUMRDPT = 2;                   // read ports
  localparam int NUMWRPT = 3;                   // write ports
  localparam int BITGRP  = 2;                   // write port index
  localparam int BITPADR = BITGRP + BITADDR;    // group above word address

  // ##################################################################
  // command and response words
  // ##################################################################

  typedef struct packed {
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
  } wr_cmd_t;

  typedef struct packed {
    logic               read;
    logic [BITADDR-1:0] addr;
  } rd_cmd_t;

  typedef struct packed {
    logic               vld;
    logic [WIDTH-1:0]   dout;
    logic [BITPADR-1:0] padr;   // {group, addr}
  } rd_rsp_t;

endpackage

/* verilog/mrpw_ram_1r1w.sv */
`timescale 1ns/1ps

module mrpw_ram_1r1w (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [mrpw_pkg::BITADDR-1:0] wr_addr,
  input  logic [mrpw_pkg::WIDTH-1:0]   wr_data,
  input  logic                         rd_en,
  input  logic [mrpw_pkg::BITADDR-1:0] rd_addr,
  output logic [mrpw_pkg::WIDTH-1:0]   rd_data
);

  logic [mrpw_pkg::WIDTH-1:0] mem [mrpw_pkg::NUMADDR];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, same-edge write is not seen
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/mrpw_lvt.sv */
`timescale 1ns/1ps

module mrpw_lvt (
  input  logic                        clk,
  input  logic                        arst_n,
  input  mrpw_pkg::wr_cmd_t           wr_q [mrpw_pkg::NUMWRPT],
  input  mrpw_pkg::rd_cmd_t           rd_q [mrpw_pkg::NUMRDPT],
  output logic [mrpw_pkg::BITGRP-1:0] grp  [mrpw_pkg::NUMRDPT]
);

  // last writer port per address
  logic [mrpw_pkg::BITGRP-1:0] lvt [mrpw_pkg::NUMADDR];

  // ##################################################################
  // table update
  // ##################################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int a = 0; a < mrpw_pkg::NUMADDR; a++) begin
        lvt[a] <= '0;
      end
    end else begin
      for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
        if (wr_q[w].write) begin
          lvt[wr_q[w].addr] <= mrpw_pkg::BITGRP'(w);  // at most one port per addr
        end
      end
    end
  end

  // ##################################################################
  // table lookup
  // ##################################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
        grp[r] <= '0;
      end
    end else begin
      for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
        if (rd_q[r].read) begin
          grp[r] <= lvt[rd_q[r].addr];  // old owner on same-edge write
        end
      end
    end
  end

endmodule

/* verilog/mrpw_port_ctrl.sv */
`timescale 1ns/1ps

module mrpw_port_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  mrpw_pkg::wr_cmd_t wr   [mrpw_pkg::NUMWRPT],
  input  mrpw_pkg::rd_cmd_t rd   [mrpw_pkg::NUMRDPT],
  output mrpw_pkg::wr_cmd_t wr_q [mrpw_pkg::NUMWRPT],
  output mrpw_pkg::rd_cmd_t rd_q [mrpw_pkg::NUMRDPT],
  output mrpw_pkg::rd_cmd_t rd_d [mrpw_pkg::NUMRDPT],
  output logic              ready
);

  logic [mrpw_pkg::BITADDR-1:0] init_cnt;
  mrpw_pkg::wr_cmd_t            wr_nxt [mrpw_pkg::NUMWRPT];
  mrpw_pkg::rd_cmd_t            rd_nxt [mrpw_pkg::NUMRDPT];

  // ##################################################################
  // init sequencer
  // ##################################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_cnt <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_cnt <= init_cnt + 1'b1;
      if (int'(init_cnt) == mrpw_pkg::NUMADDR - 1) begin
        ready <= 1'b1;  // counter wraps here
      end
    end
  end

  // ##################################################################
  // next command, highest write port wins an address
  // ##################################################################

  always_comb begin
    for (int i = 0; i < mrpw_pkg::NUMWRPT; i++) begin
      wr_nxt[i] = wr[i];
      for (int j = i + 1; j < mrpw_pkg::NUMWRPT; j++) begin
        if (wr[j].write && (wr[j].addr == wr[i].addr)) begin
          wr_nxt[i].write = 1'b0;
        end
      end
      if (!ready) begin
        wr_nxt[i] = '0;  // outside writes blocked
      end
    end
    if (!ready) begin
      wr_nxt[0].write = 1'b1;  // zero fill
      wr_nxt[0].addr  = init_cnt;
    end
    for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
      rd_nxt[r] = ready ? rd[r] : '0;
    end
  end

  // input register and read delay stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_q <= '{default: '0};
      rd_q <= '{default: '0};
      rd_d <= '{default: '0};
    end else begin
      wr_q <= wr_nxt;
      rd_q <= rd_nxt;
      rd_d <= rd_q;  // lines up with bank and table outputs
    end
  end

endmodule

/* verilog/mrpw_bank_array.sv */
`timescale 1ns/1ps

module mrpw_bank_array (
  input  logic                       clk,
  input  mrpw_pkg::wr_cmd_t          wr_q [mrpw_pkg::NUMWRPT],
  input  mrpw_pkg::rd_cmd_t          rd_q [mrpw_pkg::NUMRDPT],
  output logic [mrpw_pkg::WIDTH-1:0] bank_dout [mrpw_pkg::NUMWRPT][mrpw_pkg::NUMRDPT]
);

  // ##################################################################
  // replica grid
  // every write port keeps one copy of memory per read port, so each
  // 1r1w bank sees exactly one writer and one reader per cycle
  // ##################################################################

  for (genvar w = 0; w < mrpw_pkg::NUMWRPT; w++) begin : g_wr
    for (genvar r = 0; r < mrpw_pkg::NUMRDPT; r++) begin : g_rd

      mrpw_ram_1r1w u_ram (
        .clk     (clk),
        .wr_en   (wr_q[w].write),  // all replicas of port w
        .wr_addr (wr_q[w].addr),
        .wr_data (wr_q[w].din),
        .rd_en   (rd_q[r].read),   // replica r serves read port r
        .rd_addr (rd_q[r].addr),
        .rd_data (bank_dout[w][r])
      );

    end
  end

endmodule

/* verilog/mrpw_rd_select.sv */
`timescale 1ns/1ps

module mrpw_rd_select (
  input  mrpw_pkg::rd_cmd_t          rd_d [mrpw_pkg::NUMRDPT],
  input  logic [mrpw_pkg::BITGRP-1:0] grp [mrpw_pkg::NUMRDPT],
  input  logic [mrpw_pkg::WIDTH-1:0] bank_dout [mrpw_pkg::NUMWRPT][mrpw_pkg::NUMRDPT],
  output mrpw_pkg::rd_rsp_t          rsp  [mrpw_pkg::NUMRDPT]
);

  // ##################################################################
  // per read port output mux
  // ##################################################################

  always_comb begin
    for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
      rsp[r].vld  = rd_d[r].read;
      rsp[r].dout = '0;
      rsp[r].padr = '0;
      if (rd_d[r].read) begin
        for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
          if (int'(grp[r]) == w) begin
            rsp[r].dout = bank_dout[w][r];  // live replica
          end
        end
        rsp[r].padr = {grp[r], rd_d[r].addr};
      end
    end
  end

endmodule

/* verilog/mrpw_top.sv */
`timescale 1ns/1ps

module mrpw_top (
  input  logic              clk,
  input  logic              arst_n,
  input  mrpw_pkg::wr_cmd_t wr  [mrpw_pkg::NUMWRPT],
  input  mrpw_pkg::rd_cmd_t rd  [mrpw_pkg::NUMRDPT],
  output mrpw_pkg::rd_rsp_t rsp [mrpw_pkg::NUMRDPT],
  output logic              ready
);

  mrpw_pkg::wr_cmd_t          wr_q [mrpw_pkg::NUMWRPT];
  mrpw_pkg::rd_cmd_t          rd_q [mrpw_pkg::NUMRDPT];
  mrpw_pkg::rd_cmd_t          rd_d [mrpw_pkg::NUMRDPT];
  logic [mrpw_pkg::BITGRP-1:0] grp [mrpw_pkg::NUMRDPT];
  logic [mrpw_pkg::WIDTH-1:0] bank_dout [mrpw_pkg::NUMWRPT][mrpw_pkg::NUMRDPT];

  // ##################################################################
  // command stage
  // ##################################################################

  mrpw_port_ctrl u_port_ctrl (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .rd     (rd),
    .wr_q   (wr_q),
    .rd_q   (rd_q),
    .rd_d   (rd_d),
    .ready  (ready)
  );

  // ##################################################################
  // storage
  // ##################################################################

  mrpw_lvt u_lvt (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_q   (wr_q),
    .rd_q   (rd_q),
    .grp    (grp)
  );

  mrpw_bank_array u_bank_array (
    .clk       (clk),
    .wr_q      (wr_q),
    .rd_q      (rd_q),
    .bank_dout (bank_dout)
  );

  // ##################################################################
  // read select
  // ##################################################################

  mrpw_rd_select u_rd_select (
    .rd_d      (rd_d),
    .grp       (grp),
    .bank_dout (bank_dout),
    .rsp       (rsp)
  );

endmodule

/* dv/mrpw_tb.sv */
`timescale 1ns/1ps

module mrpw_tb;

  localparam int N_RAND   = 400;
  localparam int RDY_WAIT = mrpw_pkg::NUMADDR + 32;

  logic              clk;
  logic              arst_n;
  mrpw_pkg::wr_cmd_t wr  [mrpw_pkg::NUMWRPT];
  mrpw_pkg::rd_cmd_t rd  [mrpw_pkg::NUMRDPT];
  mrpw_pkg::rd_rsp_t rsp [mrpw_pkg::NUMRDPT];
  logic              ready;

  mrpw_pkg::wr_cmd_t nxt_wr [mrpw_pkg::NUMWRPT];  // staged for the next drive
  mrpw_pkg::rd_cmd_t nxt_rd [mrpw_pkg::NUMRDPT];

  logic [mrpw_pkg::WIDTH-1:0]  ref_mem   [mrpw_pkg::NUMADDR];
  logic [mrpw_pkg::BITGRP-1:0] ref_owner [mrpw_pkg::NUMADDR];  // last writer port
  mrpw_pkg::rd_rsp_t           cur_exp   [mrpw_pkg::NUMRDPT];
  mrpw_pkg::rd_rsp_t           exp_q1    [mrpw_pkg::NUMRDPT];
  mrpw_pkg::rd_rsp_t           exp_q2    [mrpw_pkg::NUMRDPT];

  logic [31:0] lfsr;
  int          vld_errs;
  int          dout_errs;
  int          padr_errs;
  int          other_errs;

  mrpw_top DUT (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .rd     (rd),
    .rsp    (rsp),
    .ready  (ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ##################################################################
  // expected response pipe and checks
  // ##################################################################

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_q1 <= '{default: '0};
      exp_q2 <= '{default: '0};
    end else begin
      exp_q1 <= cur_exp;
      exp_q2 <= exp_q1;  // response lands two edges after the drive
    end
  end

  for (genvar r = 0; r < mrpw_pkg::NUMRDPT; r++) begin : g_chk
    a_vld: assert property (@(posedge clk) disable iff (!arst_n)
        rsp[r].vld == exp_q2[r].vld)
      else begin
        vld_errs++;
        $display("error: rsp[%0d].vld exp %h got %h", r,
                 $sampled(exp_q2[r].vld), $sampled(rsp[r].vld));
      end
    a_dout: assert property (@(posedge clk) disable iff (!arst_n)
        rsp[r].dout == exp_q2[r].dout)
      else begin
        dout_errs++;
        $display("error: rsp[%0d].dout exp %h got %h", r,
                 $sampled(exp_q2[r].dout), $sampled(rsp[r].dout));
      end
    a_padr: assert property (@(posedge clk) disable iff (!arst_n)
        rsp[r].padr == exp_q2[r].padr)
      else begin
        padr_errs++;
        $display("error: rsp[%0d].padr exp %h got %h", r,
                 $sampled(exp_q2[r].padr), $sampled(rsp[r].padr));
      end
    a_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !ready |-> !rsp[r].vld)
      else begin
        vld_errs++;
        $display("error: rsp[%0d].vld exp 0 got 1 while ready is low", r);
      end
  end

  // ##################################################################
  // stimulus helpers
  // ##################################################################

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic clear_cmds();
    for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
      nxt_wr[w] = '0;
    end
    for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
      nxt_rd[r] = '0;
    end
  endtask

  // drive one cycle, reads see the model before this cycle's writes
  task automatic issue_cycle();
    @(posedge clk);
    #1;
    for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
      cur_exp[r] = '0;
      if (nxt_rd[r].read) begin
        cur_exp[r].vld  = 1'b1;
        cur_exp[r].dout = ref_mem[nxt_rd[r].addr];
        cur_exp[r].padr = {ref_owner[nxt_rd[r].addr], nxt_rd[r].addr};
      end
      rd[r] = nxt_rd[r];
    end
    for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
      if (nxt_wr[w].write) begin
        ref_mem[nxt_wr[w].addr]   = nxt_wr[w].din;  // higher port overwrites
        ref_owner[nxt_wr[w].addr] = mrpw_pkg::BITGRP'(w);
      end
      wr[w] = nxt_wr[w];
    end
  endtask

  // random commands on every port while ready is low, all to be dropped
  task automatic drive_blocked();
    logic [31:0] v;
    for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
      take_bits(mrpw_pkg::BITADDR, v);
      wr[w].addr  = v[mrpw_pkg::BITADDR-1:0];
      take_bits(mrpw_pkg::WIDTH, v);
      wr[w].din   = v[mrpw_pkg::WIDTH-1:0];
      wr[w].write = 1'b1;
    end
    for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
      take_bits(mrpw_pkg::BITADDR, v);
      rd[r].addr = v[mrpw_pkg::BITADDR-1:0];
      rd[r].read = 1'b1;
      cur_exp[r] = '0;
    end
  endtask

  task automatic wait_ready(output bit ok);
    int cnt;
    ok  = 1'b0;
    cnt = 0;
    while (!ok && cnt < RDY_WAIT) begin
      @(posedge clk);
      #1;
      cnt++;
      ok = ready;
      if (ok) begin
        wr = '{default: '0};
        rd = '{default: '0};
      end else begin
        drive_blocked();
      end
    end
    if (!ok) begin
      other_errs++;
      $display("ready did not rise within %0d cycles after reset", RDY_WAIT);
    end else if (cnt < mrpw_pkg::NUMADDR) begin
      other_errs++;
      $display("ready rose after only %0d cycles, before init could finish", cnt);
    end
  endtask

  // ##################################################################
  // test sequences
  // ##################################################################

  task automatic read_all();
    for (int a = 0; a < mrpw_pkg::NUMADDR; a++) begin
      clear_cmds();
      nxt_rd[0].read = 1'b1;
      nxt_rd[0].addr = mrpw_pkg::BITADDR'(a);
      nxt_rd[1].read = 1'b1;
      nxt_rd[1].addr = mrpw_pkg::BITADDR'(mrpw_pkg::NUMADDR - 1 - a);
      issue_cycle();
    end
  endtask

  task automatic run_random(input int n);
    logic [31:0] v;
    for (int c = 0; c < n; c++) begin
      for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
        take_bits(1, v);
        nxt_wr[w].write = v[0];
        take_bits(mrpw_pkg::BITADDR, v);
        nxt_wr[w].addr = v[mrpw_pkg::BITADDR-1:0];
        take_bits(mrpw_pkg::WIDTH, v);
        nxt_wr[w].din = v[mrpw_pkg::WIDTH-1:0];
      end
      for (int r = 0; r < mrpw_pkg::NUMRDPT; r++) begin
        take_bits(1, v);
        nxt_rd[r].read = v[0];
        take_bits(mrpw_pkg::BITADDR, v);
        nxt_rd[r].addr = v[mrpw_pkg::BITADDR-1:0];
      end
      issue_cycle();
    end
  endtask

  // k = 0 all ports, k = 1 ports 0 and 1, k = 2 ports 0 and 2
  task automatic run_collisions();
    int k;
    for (int a = 0; a < mrpw_pkg::NUMADDR; a += 5) begin
      k = a % 3;
      clear_cmds();
      for (int w = 0; w < mrpw_pkg::NUMWRPT; w++) begin
        nxt_wr[w].write = (w == 0) || (k == 0) || (w == k);
        nxt_wr[w].addr  = mrpw_pkg::BITADDR'(a);
        nxt_wr[w].din   = mrpw_pkg::WIDTH'(16'hc000 + (w << 8) + a);
      end
      issue_cycle();
      clear_cmds();
      nxt_rd[a % 2].read = 1'b1;
      nxt_rd[a % 2].addr = mrpw_pkg::BITADDR'(a);
      issue_cycle();
    end
  endtask

  task automatic run_same_edge();
    int a;
    for (int i = 0; i < 12; i++) begin
      a = (i * 7 + 3) % mrpw_pkg::NUMADDR;
      clear_cmds();
      nxt_wr[i % mrpw_pkg::NUMWRPT].write = 1'b1;
      nxt_wr[i % mrpw_pkg::NUMWRPT].addr  = mrpw_pkg::BITADDR'(a);
      nxt_wr[i % mrpw_pkg::NUMWRPT].din   = mrpw_pkg::WIDTH'(16'h5a00 + i);
      nxt_rd[0].read = 1'b1;  // old word
      nxt_rd[0].addr = mrpw_pkg::BITADDR'(a);
      issue_cycle();
      clear_cmds();
      nxt_rd[1].read = 1'b1;  // new word
      nxt_rd[1].addr = mrpw_pkg::BITADDR'(a);
      issue_cycle();
    end
  endtask

  // ##################################################################
  // main sequence
  // ##################################################################

  initial begin
    bit ok;
    arst_n     = 1'b0;
    lfsr       = 32'h874c;
    vld_errs   = 0;
    dout_errs  = 0;
    padr_errs  = 0;
    other_errs = 0;
    wr         = '{default: '0};
    rd         = '{default: '0};
    cur_exp    = '{default: '0};
    clear_cmds();
    for (int a = 0; a < mrpw_pkg::NUMADDR; a++) begin
      ref_mem[a]   = '0;  // init fills port 0 with zero
      ref_owner[a] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    a_rdy_low: assert (ready == 1'b0)
      else begin
        other_errs++;
        $display("error: ready exp %h got %h", 1'b0, ready);
      end
    wait_ready(ok);
    if (ok) begin
      read_all();
      run_random(N_RAND);
      run_collisions();
      run_same_edge();
      read_all();
    end
    clear_cmds();
    repeat (4) issue_cycle();
    $display("errors: vld %0d, dout %0d, padr %0d, other %0d",
             vld_errs, dout_errs, padr_errs, other_errs);
    if (vld_errs + dout_errs + padr_errs + other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/mrpw_pkg.sv
verilog/mrpw_ram_1r1w.sv
verilog/mrpw_lvt.sv
verilog/mrpw_port_ctrl.sv
verilog/mrpw_bank_array.sv
verilog/mrpw_rd_select.sv
verilog/mrpw_top.sv
dv/mrpw_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mrpw_tb
RTL_TOP   ?= mrpw_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint lint_rtl build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
